/* logic/bus_fabric.sv */
// ************************************************************************
// Single-host decoder. Grant is immediate and there is no back-pressure.
// Unmapped addresses get an error reply with zero data.
// ************************************************************************
`timescale 1ns/1ps
`include "periph_defines.svh"

module bus_fabric (
  input  logic                 clk_sys_i,
  input  logic                 rst_sys_ni,

  input  periph_pkg::bus_req_t host_req_i,
  output periph_pkg::bus_rsp_t host_rsp_o,
  output logic                 gnt_o,

  output periph_pkg::bus_req_t gpio_req_o,
  output periph_pkg::bus_req_t timer_req_o,
  input  periph_pkg::bus_rsp_t gpio_rsp_i,
  input  periph_pkg::bus_rsp_t timer_rsp_i
);
  import periph_pkg::*;

  bus_device_e dev_sel;
  bus_device_e dev_q;
  logic        unmapped_q;

  always_comb begin
    dev_sel = dev_none;
    if ((host_req_i.addr & `PERIPH_GPIO_MASK) == `PERIPH_GPIO_START) begin
      dev_sel = dev_gpio;
    end else if ((host_req_i.addr & `PERIPH_TIMER_MASK) == `PERIPH_TIMER_START) begin
      dev_sel = dev_timer;
    end
  end

  assign gnt_o = host_req_i.req;  // Only one host.

  // Devices see the offset within their own window.
  always_comb begin
    gpio_req_o      = host_req_i;
    gpio_req_o.req  = host_req_i.req && (dev_sel == dev_gpio);
    gpio_req_o.addr = host_req_i.addr & ~`PERIPH_GPIO_MASK;

    timer_req_o      = host_req_i;
    timer_req_o.req  = host_req_i.req && (dev_sel == dev_timer);
    timer_req_o.addr = host_req_i.addr & ~`PERIPH_TIMER_MASK;
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      dev_q      <= dev_none;
      unmapped_q <= 1'b0;
    end else begin
      dev_q      <= dev_sel;
      unmapped_q <= host_req_i.req && (dev_sel == dev_none);
    end
  end

  // Reply comes from the device picked in the previous cycle.
  always_comb begin
    case (dev_q)
      dev_gpio: begin
        host_rsp_o = gpio_rsp_i;
      end
      dev_timer: begin
        host_rsp_o = timer_rsp_i;
      end
      default: begin
        host_rsp_o.rvalid = unmapped_q;
        host_rsp_o.rdata  = '0;
        host_rsp_o.err    = unmapped_q;  // Bus error.
      end
    endcase
  end

endmodule

/* logic/gpio_regs.sv */
// ************************************************************************
// GPIO with the output word at 0x0 and the synchronized inputs at 0x4.
// Inputs are visible two cycles after they settle. No error replies.
// ************************************************************************
`timescale 1ns/1ps
`include "periph_defines.svh"

module gpio_regs (
  input  logic                      clk_sys_i,
  input  logic                      rst_sys_ni,

  input  periph_pkg::bus_req_t      req_i,
  output periph_pkg::bus_rsp_t      rsp_o,

  input  logic [`PERIPH_GPI_W-1:0]  gp_i,
  output logic [`PERIPH_GPO_W-1:0]  gp_o
);
  import periph_pkg::*;

  logic [`PERIPH_GPI_W-1:0]  gpi_meta_q;
  logic [`PERIPH_GPI_W-1:0]  gpi_sync_q;
  logic [`PERIPH_GPO_W-1:0]  gpo_q;
  logic [`PERIPH_DATA_W-1:0] gpo_merged;
  logic [`PERIPH_DATA_W-1:0] rd_word;
  logic                      rvalid_q;
  logic [`PERIPH_DATA_W-1:0] rdata_q;
  logic                      sel_out;
  logic                      sel_in;

  assign sel_out = (req_i.addr[11:0] == 12'h000);
  assign sel_in  = (req_i.addr[11:0] == 12'h004);

  assign gpo_merged = merge_be(`PERIPH_DATA_W'(gpo_q), req_i.wdata, req_i.be);

  always_comb begin
    rd_word = '0;
    if (sel_out) rd_word = `PERIPH_DATA_W'(gpo_q);
    else if (sel_in) rd_word = `PERIPH_DATA_W'(gpi_sync_q);  // Zero-extended.
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      gpo_q      <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      rvalid_q   <= req_i.req;
      if (req_i.req && req_i.we && sel_out) begin
        gpo_q <= gpo_merged[`PERIPH_GPO_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    rdata_q <= (req_i.req && !req_i.we) ? rd_word : '0;  // Writes reply zero.
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = 1'b0;
  assign gp_o         = gpo_q;

endmodule

/* logic/periph_defines.svh */
// ************************************************************************
// Fixed bus widths and address map of the peripheral subsystem.
// Windows are 4 KiB and must stay aligned to their size.
// ************************************************************************
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Bus widths.
`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32
`define PERIPH_BE_W   4

// GPIO pin counts of at most one data word each.
`define PERIPH_GPI_W  8
`define PERIPH_GPO_W  16

// Address map.
`define PERIPH_GPIO_START  32'h80000000
`define PERIPH_GPIO_MASK   32'hFFFFF000  // 4 KiB window.
`define PERIPH_TIMER_START 32'h80002000
`define PERIPH_TIMER_MASK  32'hFFFFF000  // 4 KiB window.

`endif

/* logic/periph_pkg.sv */
// ************************************************************************
// Bus structs and enums shared by the fabric and the devices.
// ************************************************************************
`include "periph_defines.svh"

package periph_pkg;

  // Host or fabric request that is valid while req is high.
  typedef struct packed {
    logic                      req;
    logic [`PERIPH_ADDR_W-1:0] addr;
    logic                      we;
    logic [`PERIPH_BE_W-1:0]   be;
    logic [`PERIPH_DATA_W-1:0] wdata;
  } bus_req_t;

  // Reply that comes one cycle after the request.
  typedef struct packed {
    logic                      rvalid;
    logic [`PERIPH_DATA_W-1:0] rdata;
    logic                      err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    dev_gpio  = 2'd0,
    dev_timer = 2'd1,
    dev_none  = 2'd2
  } bus_device_e;

  // Byte offsets of the timer words.
  typedef enum logic [3:0] {
    reg_mtime_lo = 4'h0,
    reg_mtime_hi = 4'h4,
    reg_cmp_lo   = 4'h8,
    reg_cmp_hi   = 4'hC
  } timer_reg_e;

  // Replaces the enabled bytes of old_val with those of wdata.
  function automatic logic [`PERIPH_DATA_W-1:0] merge_be(
    input logic [`PERIPH_DATA_W-1:0] old_val,
    input logic [`PERIPH_DATA_W-1:0] wdata,
    input logic [`PERIPH_BE_W-1:0]   be
  );
    logic [`PERIPH_DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < `PERIPH_BE_W; i++) begin
      if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

endpackage

/* logic/periph_top.sv */
// ************************************************************************
// Peripheral subsystem with a GPIO and a timer for one external bus host.
// Every request gets its reply in the following cycle.
// ************************************************************************
`timescale 1ns/1ps
`include "periph_defines.svh"

module periph_top (
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,

  input  periph_pkg::bus_req_t     bus_i,
  output logic                     gnt_o,
  output periph_pkg::bus_rsp_t     bus_o,

  input  logic [`PERIPH_GPI_W-1:0] gp_i,
  output logic [`PERIPH_GPO_W-1:0] gp_o,
  output logic                     irq_o
);
  import periph_pkg::*;

  bus_req_t gpio_req;
  bus_req_t timer_req;
  bus_rsp_t gpio_rsp;
  bus_rsp_t timer_rsp;

  bus_fabric u_bus_fabric (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .host_req_i (bus_i),
    .host_rsp_o (bus_o),
    .gnt_o      (gnt_o),
    .gpio_req_o (gpio_req),
    .timer_req_o(timer_req),
    .gpio_rsp_i (gpio_rsp),
    .timer_rsp_i(timer_rsp)
  );

  gpio_regs u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (gpio_req),
    .rsp_o     (gpio_rsp),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  timer_regs u_timer (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (timer_req),
    .rsp_o     (timer_rsp),
    .irq_o     (irq_o)   // Compare interrupt level.
  );

endmodule

/* logic/timer_regs.sv */
// ************************************************************************
// 64-bit mtime/mtimecmp timer, accessed as 32-bit words.
// irq_o lags the compare by one cycle; offsets past 0xC reply an error.
// ************************************************************************
`timescale 1ns/1ps
`include "periph_defines.svh"

module timer_regs (
  input  logic                 clk_sys_i,
  input  logic                 rst_sys_ni,

  input  periph_pkg::bus_req_t req_i,
  output periph_pkg::bus_rsp_t rsp_o,

  output logic                 irq_o
);
  import periph_pkg::*;

  logic [63:0]               mtime_q;
  logic [63:0]               mtime_d;
  logic [63:0]               cmp_q;
  logic [63:0]               cmp_d;
  logic                      irq_q;
  timer_reg_e                reg_sel;
  logic                      bad_offset;
  logic                      wr_en;
  logic                      rd_en;
  logic [`PERIPH_DATA_W-1:0] rd_word;
  logic                      rvalid_q;
  logic                      err_q;
  logic [`PERIPH_DATA_W-1:0] rdata_q;

  assign reg_sel    = timer_reg_e'({req_i.addr[3:2], 2'b00});
  assign bad_offset = |req_i.addr[11:4];
  assign wr_en      = req_i.req && req_i.we && !bad_offset;
  assign rd_en      = req_i.req && !req_i.we && !bad_offset;

  // Counter advances unless software writes it this cycle.
  always_comb begin
    mtime_d = mtime_q + 64'd1;
    cmp_d   = cmp_q;
    if (wr_en) begin
      case (reg_sel)
        reg_mtime_lo: begin
          mtime_d = {mtime_q[63:32], merge_be(mtime_q[31:0], req_i.wdata, req_i.be)};
        end
        reg_mtime_hi: begin
          mtime_d = {merge_be(mtime_q[63:32], req_i.wdata, req_i.be), mtime_q[31:0]};
        end
        reg_cmp_lo: begin
          cmp_d[31:0] = merge_be(cmp_q[31:0], req_i.wdata, req_i.be);
        end
        reg_cmp_hi: begin
          cmp_d[63:32] = merge_be(cmp_q[63:32], req_i.wdata, req_i.be);
        end
        default: begin
          cmp_d = cmp_q;
        end
      endcase
    end
  end

  always_comb begin
    case (reg_sel)
      reg_mtime_lo: rd_word = mtime_q[31:0];
      reg_mtime_hi: rd_word = mtime_q[63:32];
      reg_cmp_lo:   rd_word = cmp_q[31:0];
      reg_cmp_hi:   rd_word = cmp_q[63:32];
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q  <= '0;
      cmp_q    <= '1;  // No interrupt until software sets a compare.
      irq_q    <= 1'b0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      mtime_q  <= mtime_d;
      cmp_q    <= cmp_d;
      irq_q    <= (mtime_q >= cmp_q);
      rvalid_q <= req_i.req;
      err_q    <= req_i.req && bad_offset;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    rdata_q <= rd_en ? rd_word : '0;
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = err_q;
  assign irq_o        = irq_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds periph_tb with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module periph_tb -f sources.f \
  -o periph_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/periph_sim +verilator+error+limit+100 2>&1)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && exit 0 || { echo "Simulation failed"; exit 1; }

/* sources.f */
+incdir+logic
logic/periph_pkg.sv
logic/bus_fabric.sv
logic/gpio_regs.sv
logic/timer_regs.sv
logic/periph_top.sv
testbench/periph_assertions.sv
testbench/periph_tb.sv

/* testbench/periph_assertions.sv */
// ************************************************************************
// Bus protocol checks on periph_top for the grant and one reply per request.
// ************************************************************************
`timescale 1ns/1ps
`include "periph_defines.svh"

module periph_assertions (
  input logic                 clk_sys_i,
  input logic                 rst_sys_ni,
  input periph_pkg::bus_req_t bus_i,
  input logic                 gnt_o,
  input periph_pkg::bus_rsp_t bus_o
);
  import periph_pkg::*;

  int   fail_count = 0;
  logic unmapped;

  assign unmapped = ((bus_i.addr & `PERIPH_GPIO_MASK) != `PERIPH_GPIO_START) &&
                    ((bus_i.addr & `PERIPH_TIMER_MASK) != `PERIPH_TIMER_START);

  // Single host, so the grant is the request.
  grant_is_req: assert property (@(posedge clk_sys_i) gnt_o == bus_i.req)
    else begin
      $error("gnt_o differs from the request strobe");
      fail_count++;
    end

  reply_after_req: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus_i.req |=> bus_o.rvalid)
    else begin
      $error("request without a reply in the next cycle");
      fail_count++;
    end

  no_stray_reply: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !bus_i.req |=> !bus_o.rvalid)
    else begin
      $error("reply without a request in the previous cycle");
      fail_count++;
    end

  write_reply_zero: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus_i.req && bus_i.we |=> bus_o.rdata == '0)
    else begin
      $error("write reply carries nonzero data");
      fail_count++;
    end

  unmapped_error: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    bus_i.req && unmapped |=> bus_o.err && bus_o.rdata == '0)
    else begin
      $error("unmapped address without an error reply");
      fail_count++;
    end

endmodule

bind periph_top periph_assertions u_periph_assertions (
  .clk_sys_i (clk_sys_i),
  .rst_sys_ni(rst_sys_ni),
  .bus_i     (bus_i),
  .gnt_o     (gnt_o),
  .bus_o     (bus_o)
);

/* testbench/periph_tb.sv */
// ************************************************************************
// Directed and random tests of periph_top against a reference model.
// Bus protocol timing is checked by the bound assertions module.
// ************************************************************************
`timescale 1ns/1ps
`include "periph_defines.svh"

module periph_tb;
  import periph_pkg::*;

  localparam int clk_period = 40;
  localparam int irq_ahead  = 20;  // Compare distance ahead of mtime.
  // Reset, gpio writes, gpio inputs, counting, irq, errors, burst, drain.
  localparam int test_cycles = 4 + 8*5 + 4*7 + 4*14 + (2*irq_ahead + 16) + 4*3 + 26 + 2;
  localparam int watchdog_cycles = 2 * test_cycles + 100;
  localparam logic [31:0] gpio_base  = `PERIPH_GPIO_START;
  localparam logic [31:0] timer_base = `PERIPH_TIMER_START;

  logic                     clk_sys = 1'b0;
  logic                     rst_sys_n;
  bus_req_t                 bus_req;
  bus_rsp_t                 bus_rsp;
  logic                     gnt;
  logic [`PERIPH_GPI_W-1:0] gp_in;
  logic [`PERIPH_GPO_W-1:0] gp_out;
  logic                     irq;

  integer                   seed = 32'h9ec6;
  int                       errors = 0;
  int                       tests_run = 0;
  int                       tests_failed = 0;
  logic [`PERIPH_GPO_W-1:0] gpo_model = '0;

  periph_top dut_i (
    .clk_sys_i (clk_sys),
    .rst_sys_ni(rst_sys_n),
    .bus_i     (bus_req),
    .gnt_o     (gnt),
    .bus_o     (bus_rsp),
    .gp_i      (gp_in),
    .gp_o      (gp_out),
    .irq_o     (irq)
  );

  always #(clk_period / 2) clk_sys = ~clk_sys;

  // Enabled bytes come from the new word.
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_sys);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // One request cycle, then wait for the reply.
  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge clk_sys);
    #1;
    bus_req.req   = 1'b1;
    bus_req.addr  = addr;
    bus_req.we    = wr;
    bus_req.be    = be;
    bus_req.wdata = wdata;
    @(posedge clk_sys);
    #1;
    bus_req.req = 1'b0;
    while (!bus_rsp.rvalid && waited < 4) begin
      @(posedge clk_sys);
      #1;
      waited++;
    end
    assert (bus_rsp.rvalid) else begin
      $display("no response to the request at address 0x%h", addr);
      errors++;
    end
    rdata = bus_rsp.rdata;
    err   = bus_rsp.err;
  endtask

  task automatic irq_hold(input logic level, input int cycles);
    repeat (cycles) begin
      @(posedge clk_sys);
      #1;
      check_word("irq_o", 32'(irq), 32'(level));
    end
  endtask

  task automatic finish_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - start);
    end
  endtask

  task automatic gpio_write_test(input int rounds);
    logic [31:0] rnd;
    logic [31:0] wdata;
    logic [31:0] merged;
    logic [31:0] rdata;
    logic        err;
    int          start;
    start = errors;
    for (int i = 0; i < rounds; i++) begin
      rnd       = $random(seed);
      wdata     = $random(seed);
      merged    = merge_bytes(32'(gpo_model), wdata, rnd[3:0]);
      gpo_model = merged[`PERIPH_GPO_W-1:0];  // Upper bytes have no pins.
      bus_access(1'b1, gpio_base, rnd[3:0], wdata, rdata, err);
      check_word("gp_o", 32'(gp_out), 32'(gpo_model));
      bus_access(1'b0, gpio_base, 4'hF, '0, rdata, err);
      check_word("bus_o.rdata", rdata, 32'(gpo_model));
      check_word("bus_o.err", 32'(err), 32'h0);
    end
    finish_test("gpio_write", start);
  endtask

  task automatic gpio_input_test(input int rounds);
    logic [31:0] rnd;
    logic [31:0] rdata;
    logic        err;
    int          start;
    start = errors;
    for (int i = 0; i < rounds; i++) begin
      rnd   = $random(seed);
      gp_in = rnd[`PERIPH_GPI_W-1:0];
      idle_cycles(3);  // Covers the two synchronizer stages.
      bus_access(1'b0, gpio_base + 32'h4, 4'hF, '0, rdata, err);
      check_word("bus_o.rdata", rdata, 32'(gp_in));
    end
    finish_test("gpio_input", start);
  endtask

  task automatic timer_count_test(input int rounds);
    logic [31:0] rnd;
    logic [31:0] wval;
    logic [31:0] rdata;
    logic        err;
    int          gap;
    int          start;
    start = errors;
    for (int i = 0; i < rounds; i++) begin
      rnd  = $random(seed);
      wval = rnd & 32'h0FFF_FFFF;  // No wrap of the low word.
      gap  = 3 * i;
      bus_access(1'b1, timer_base + 32'(reg_mtime_lo), 4'hF, wval, rdata, err);
      idle_cycles(gap);
      bus_access(1'b0, timer_base + 32'(reg_mtime_lo), 4'hF, '0, rdata, err);
      // Read request lands gap + 2 cycles after the write.
      check_word("mtime_lo", rdata, wval + 32'(gap) + 32'd1);
    end
    finish_test("timer_count", start);
  endtask

  task automatic irq_test();
    logic [31:0] rnd;
    logic [31:0] mval;
    logic [31:0] rdata;
    logic        err;
    int          waited;
    int          start;
    start = errors;
    rnd   = $random(seed);
    mval  = rnd & 32'h0FFF_FFFF;
    bus_access(1'b1, timer_base + 32'(reg_mtime_hi), 4'hF, 32'h0, rdata, err);
    bus_access(1'b1, timer_base + 32'(reg_mtime_lo), 4'hF, mval, rdata, err);
    bus_access(1'b1, timer_base + 32'(reg_cmp_lo), 4'hF, mval + 32'(irq_ahead), rdata, err);
    bus_access(1'b1, timer_base + 32'(reg_cmp_hi), 4'hF, 32'h0, rdata, err);
    check_word("irq_o", 32'(irq), 32'h0);
    waited = 0;
    while (!irq && waited < 2 * irq_ahead) begin
      @(posedge clk_sys);
      #1;
      waited++;
    end
    assert (irq) else begin
      $display("irq_o never rose after mtime passed mtimecmp");
      errors++;
    end
    // mtime meets the compare irq_ahead + 1 cycles after its write.
    check_word("irq_o rise delay", 32'(waited), 32'(irq_ahead - 3));
    irq_hold(1'b1, 5);
    bus_access(1'b1, timer_base + 32'(reg_cmp_hi), 4'hF, 32'hFFFF_FFFF, rdata, err);
    irq_hold(1'b0, 5);
    finish_test("timer_irq", start);
  endtask

  task automatic error_test();
    logic [31:0] rdata;
    logic        err;
    int          start;
    start = errors;
    bus_access(1'b0, 32'h8000_1000, 4'hF, '0, rdata, err);  // Gap between windows.
    check_word("bus_o.err", 32'(err), 32'h1);
    check_word("bus_o.rdata", rdata, 32'h0);
    bus_access(1'b0, 32'h1000_0040, 4'hF, '0, rdata, err);
    check_word("bus_o.err", 32'(err), 32'h1);
    check_word("bus_o.rdata", rdata, 32'h0);
    bus_access(1'b0, timer_base + 32'h10, 4'hF, '0, rdata, err);
    check_word("bus_o.err", 32'(err), 32'h1);
    bus_access(1'b0, gpio_base + 32'h8, 4'hF, '0, rdata, err);
    check_word("bus_o.err", 32'(err), 32'h0);
    check_word("bus_o.rdata", rdata, 32'h0);
    finish_test("bus_errors", start);
  endtask

  // Requests go out in consecutive cycles and replies are counted as they pass.
  task automatic burst_test(input int count);
    logic [31:0] rnd;
    int          issued;
    int          seen;
    int          start;
    start  = errors;
    issued = 0;
    seen   = 0;
    for (int i = 0; i <= count; i++) begin
      @(posedge clk_sys);
      #1;
      if (bus_rsp.rvalid) seen++;
      rnd = $random(seed);
      bus_req.req = (i < count) && (rnd[11:10] != 2'b00);
      case (rnd[1:0])
        2'd0:    bus_req.addr = gpio_base + 32'({rnd[2], 2'b00});
        2'd1:    bus_req.addr = timer_base + 32'({rnd[4:2], 2'b00});
        2'd2:    bus_req.addr = 32'h4000_0000 + 32'({rnd[4:2], 2'b00});
        default: bus_req.addr = gpio_base;
      endcase
      bus_req.we    = rnd[8];
      bus_req.be    = rnd[15:12];
      bus_req.wdata = $random(seed);
      if (bus_req.req) issued++;
    end
    check_word("response count", 32'(seen), 32'(issued));
    finish_test("bus_burst", start);
  endtask

  initial begin
    bus_req   = '0;
    gp_in     = '0;
    rst_sys_n = 1'b0;
    repeat (4) @(posedge clk_sys);
    #1;
    rst_sys_n = 1'b1;
    gpio_write_test(8);
    gpio_input_test(4);
    timer_count_test(4);
    irq_test();
    error_test();
    burst_test(24);
    idle_cycles(2);
    #1;
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, dut_i.u_periph_assertions.fail_count);
    if (errors == 0 && dut_i.u_periph_assertions.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired, the run did not finish within %0d cycles", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule
